// ==== include/cam_vga_defs.svh ====
// Camera to VGA frame constants
`ifndef CAM_VGA_DEFS_SVH
`define CAM_VGA_DEFS_SVH

// ----------------------------------------
// stored frame geometry
// ----------------------------------------
`define FRAME_W 16              // pixels per line
`define FRAME_H 8               // lines per frame
`define ADDR_W  7               // covers FRAME_W*FRAME_H bytes

// ----------------------------------------
// horizontal timing, in sys_clk cycles
// ----------------------------------------
`define H_SYNC  4               // hs low
`define H_BACK  4
`define H_FRONT 2
`define H_TOTAL 26              // sync + back + FRAME_W + front

// ----------------------------------------
// vertical timing, in lines
// ----------------------------------------
`define V_SYNC  2               // vs low
`define V_BACK  2
`define V_FRONT 1
`define V_TOTAL 13              // sync + back + FRAME_H + front

`endif

// ==== src/cam_vga_pkg.sv ====
// Camera to VGA stream types
package cam_vga_pkg;

    // ----------------------------------------
    // camera word, two views
    // ----------------------------------------
    typedef struct packed {
        logic [7:0] hi;                 // first byte under href
        logic [7:0] lo;                 // second byte
    } pix_bytes_t;

    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } pix_rgb_t;

    typedef union packed {
        pix_bytes_t bytes;              // as received
        pix_rgb_t   rgb;                // as colour fields
    } pix565_u;

    // ----------------------------------------
    // pipeline streams
    // ----------------------------------------
    typedef struct packed {
        logic    valid;                 // one pixel this cycle
        logic    sof;                   // first pixel of frame
        pix565_u pix;
    } rgb_stream_t;

    typedef struct packed {
        logic       valid;
        logic       sof;
        logic [7:0] y;                  // luma
    } gray_stream_t;

endpackage

// ==== src/cmos_capture.sv ====
// CMOS byte pair capture
`timescale 1ns/100ps

module cmos_capture (
    input  logic                     sys_clk,
    input  logic                     rst_n,
    input  logic                     cam_vsync,     // high between frames
    input  logic                     cam_href,      // line data valid
    input  logic [7:0]               cam_data,
    output cam_vga_pkg::rgb_stream_t pix_out
);

    logic                 vsync_d;                  // previous vsync
    logic                 vsync_fall;               // frame about to start
    logic                 sof_armed;                // next pixel opens frame
    logic                 byte_en;                  // byte counts this cycle
    logic                 byte_phase;               // 0 = hi, 1 = lo
    logic [7:0]           hi_byte;                  // held until lo arrives
    logic                 out_valid;
    logic                 out_sof;
    cam_vga_pkg::pix565_u out_pix;

    assign vsync_fall = vsync_d & ~cam_vsync;
    assign byte_en    = cam_href & ~cam_vsync;      // nothing counts in blanking

    // ----------------------------------------
    // control: phase, frame start, strobes
    // ----------------------------------------
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            vsync_d    <= 1'b0;
            sof_armed  <= 1'b0;
            byte_phase <= 1'b0;
            out_valid  <= 1'b0;
            out_sof    <= 1'b0;
        end else begin
            vsync_d <= cam_vsync;
            if (byte_en) begin
                byte_phase <= ~byte_phase;          // hi, lo, hi, ...
            end else begin
                byte_phase <= 1'b0;                 // odd byte at line end dropped
            end
            out_valid <= byte_en & byte_phase;      // lo sampled, pixel complete
            out_sof   <= byte_en & byte_phase & sof_armed;
            if (vsync_fall) begin
                sof_armed <= 1'b1;
            end else if (byte_en && byte_phase) begin
                sof_armed <= 1'b0;                  // consumed by first pixel
            end
        end
    end

    // payload, tagged by out_valid
    always_ff @(posedge sys_clk) begin
        if (byte_en && !byte_phase) begin
            hi_byte <= cam_data;
        end
        if (byte_en && byte_phase) begin
            out_pix.bytes.hi <= hi_byte;
            out_pix.bytes.lo <= cam_data;
        end
    end

    assign pix_out = '{valid: out_valid, sof: out_sof, pix: out_pix};

endmodule

// ==== src/rgb2gray.sv ====
// RGB565 to luma pipeline
`timescale 1ns/100ps

module rgb2gray (
    input  logic                      sys_clk,
    input  logic                      rst_n,
    input  cam_vga_pkg::rgb_stream_t  pix_in,
    output cam_vga_pkg::gray_stream_t gray_out
);

    logic [2:0]  vld_sr;                        // valid per stage
    logic [2:0]  sof_sr;                        // sof per stage
    logic [7:0]  r8;                            // stage 1
    logic [7:0]  g8;
    logic [7:0]  b8;
    logic [15:0] prod_r;                        // stage 2
    logic [15:0] prod_g;
    logic [15:0] prod_b;
    logic [15:0] luma_sum;                      // weights total 256, no overflow
    logic [7:0]  y_q;                           // stage 3

    // ----------------------------------------
    // side band, 3 cycles deep
    // ----------------------------------------
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_sr <= 3'b000;
            sof_sr <= 3'b000;
        end else begin
            vld_sr <= {vld_sr[1:0], pix_in.valid};
            sof_sr <= {sof_sr[1:0], pix_in.sof & pix_in.valid};
        end
    end

    assign luma_sum = prod_r + prod_g + prod_b;

    // ----------------------------------------
    // data path
    // ----------------------------------------
    always_ff @(posedge sys_clk) begin
        // stage 1: widen by repeating msbs
        r8 <= {pix_in.pix.rgb.r, pix_in.pix.rgb.r[4:2]};
        g8 <= {pix_in.pix.rgb.g, pix_in.pix.rgb.g[5:4]};
        b8 <= {pix_in.pix.rgb.b, pix_in.pix.rgb.b[4:2]};
        // stage 2: BT.601 weights scaled by 256
        prod_r <= 16'd77  * {8'd0, r8};
        prod_g <= 16'd150 * {8'd0, g8};
        prod_b <= 16'd29  * {8'd0, b8};
        // stage 3: sum and drop fraction
        y_q <= luma_sum[15:8];
    end

    assign gray_out = '{valid: vld_sr[2], sof: sof_sr[2], y: y_q};

endmodule

// ==== src/frame_buffer.sv ====
// Single frame luma buffer
`timescale 1ns/100ps
`include "cam_vga_defs.svh"

module frame_buffer (
    input  logic                      sys_clk,
    input  logic                      rst_n,
    input  cam_vga_pkg::gray_stream_t gray_in,
    input  logic                      rd_req,
    input  logic [`ADDR_W-1:0]        rd_addr,
    output logic [7:0]                rd_y,         // one cycle after rd_req
    output logic                      frame_ready   // sticky, first full frame
);

    localparam int DEPTH = `FRAME_W * `FRAME_H;
    localparam logic [`ADDR_W-1:0] LAST_ADDR = `ADDR_W'(DEPTH - 1);

    logic [7:0]         mem [DEPTH];                // row major luma
    logic [`ADDR_W-1:0] wr_ptr;                     // next write slot
    logic [`ADDR_W-1:0] wr_addr;                    // slot used this cycle
    logic               wr_last;

    assign wr_addr = gray_in.sof ? '0 : wr_ptr;     // frame start restarts at 0
    assign wr_last = gray_in.valid && (wr_addr == LAST_ADDR);

    // ----------------------------------------
    // write pointer and ready flag
    // ----------------------------------------
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            frame_ready <= 1'b0;
        end else begin
            if (gray_in.valid) begin
                wr_ptr <= wr_last ? '0 : wr_addr + 1'b1;
            end
            if (wr_last) begin
                frame_ready <= 1'b1;                // never cleared
            end
        end
    end

    // storage, write and registered read
    always_ff @(posedge sys_clk) begin
        if (gray_in.valid) begin
            mem[wr_addr] <= gray_in.y;
        end
        if (rd_req) begin
            rd_y <= mem[rd_addr];
        end
    end

endmodule

// ==== src/vga_driver.sv ====
// VGA timing and gray pixel output
`timescale 1ns/100ps
`include "cam_vga_defs.svh"

module vga_driver (
    input  logic                sys_clk,
    input  logic                rst_n,
    input  logic                frame_ready,
    input  logic [7:0]          rd_y,
    output logic                rd_req,         // one cycle before active pixel
    output logic [`ADDR_W-1:0]  rd_addr,
    output logic                vga_hs,         // active low
    output logic                vga_vs,         // active low
    output logic [15:0]         vga_rgb
);

    localparam int HCW   = $clog2(`H_TOTAL);
    localparam int VCW   = $clog2(`V_TOTAL);
    localparam int H_ACT = `H_SYNC + `H_BACK;   // first active column
    localparam int V_ACT = `V_SYNC + `V_BACK;   // first active line

    logic [HCW-1:0] h_cnt;
    logic [VCW-1:0] v_cnt;
    logic           h_end;
    logic           v_end;
    logic           h_act;
    logic           v_act;
    logic [HCW-1:0] col;
    logic [VCW-1:0] row;
    logic           act_q;                      // rd_req delayed, matches rd_y

    assign h_end = (h_cnt == HCW'(`H_TOTAL - 1));
    assign v_end = (v_cnt == VCW'(`V_TOTAL - 1));
    assign h_act = (h_cnt >= HCW'(H_ACT)) && (h_cnt < HCW'(H_ACT + `FRAME_W));
    assign v_act = (v_cnt >= VCW'(V_ACT)) && (v_cnt < VCW'(V_ACT + `FRAME_H));

    // ----------------------------------------
    // line and frame counters
    // ----------------------------------------
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_end) begin
                h_cnt <= '0;
                v_cnt <= v_end ? '0 : v_cnt + 1'b1;
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // read side, one cycle ahead of the screen
    assign col     = h_cnt - HCW'(H_ACT);
    assign row     = v_cnt - VCW'(V_ACT);
    assign rd_req  = h_act && v_act;
    assign rd_addr = `ADDR_W'(row * `FRAME_W + col);    // only meaningful with rd_req

    // ----------------------------------------
    // sync and blank, registered to line up with rd_y
    // ----------------------------------------
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            vga_hs <= 1'b1;
            vga_vs <= 1'b1;
            act_q  <= 1'b0;
        end else begin
            vga_hs <= (h_cnt >= HCW'(`H_SYNC));     // low at start of line
            vga_vs <= (v_cnt >= VCW'(`V_SYNC));     // low at start of frame
            act_q  <= rd_req;
        end
    end

    // luma replicated into RGB565, black until a frame is stored
    assign vga_rgb = (act_q && frame_ready) ? {rd_y[7:3], rd_y[7:2], rd_y[7:3]} : 16'd0;

endmodule

// ==== src/cam_vga_top.sv ====
// Camera to VGA grayscale top level
`timescale 1ns/100ps
`include "cam_vga_defs.svh"

module cam_vga_top (
    input  logic        sys_clk,
    input  logic        rst_n,
    // camera
    input  logic        cam_vsync,
    input  logic        cam_href,
    input  logic [7:0]  cam_data,
    // display
    output logic        vga_hs,
    output logic        vga_vs,
    output logic [15:0] vga_rgb
);

    cam_vga_pkg::rgb_stream_t  cap_pix;         // capture -> converter
    cam_vga_pkg::gray_stream_t gray_pix;        // converter -> buffer
    logic                      rd_req;
    logic [`ADDR_W-1:0]        rd_addr;
    logic [7:0]                rd_y;
    logic                      frame_ready;

    // ----------------------------------------
    // write side
    // ----------------------------------------
    cmos_capture u_capture (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .cam_vsync  (cam_vsync),
        .cam_href   (cam_href),
        .cam_data   (cam_data),
        .pix_out    (cap_pix)
    );

    rgb2gray u_gray (
        .sys_clk    (sys_clk),
        .rst_n      (rst_n),
        .pix_in     (cap_pix),
        .gray_out   (gray_pix)
    );

    frame_buffer u_fbuf (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .gray_in     (gray_pix),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_y        (rd_y),
        .frame_ready (frame_ready)
    );

    // ----------------------------------------
    // display side
    // ----------------------------------------
    vga_driver u_vga (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .frame_ready (frame_ready),
        .rd_y        (rd_y),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .vga_hs      (vga_hs),
        .vga_vs      (vga_vs),
        .vga_rgb     (vga_rgb)
    );

endmodule

// ==== test/cam_vga_properties.sv ====
// Display output assertions
`timescale 1ns/100ps
`include "cam_vga_defs.svh"

module cam_vga_properties (
    input logic        sys_clk,
    input logic        rst_n,
    input logic        vga_hs,
    input logic        vga_vs,
    input logic [15:0] vga_rgb
);

    logic [7:0] hs_low_cnt;                     // cycles of hs low so far

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            hs_low_cnt <= 8'd0;
        end else begin
            hs_low_cnt <= vga_hs ? 8'd0 : hs_low_cnt + 8'd1;
        end
    end

    // ----------------------------------------
    // sync pulse width and blanking
    // ----------------------------------------
    a_hs_width : assert property (@(posedge sys_clk) disable iff (!rst_n)
        $rose(vga_hs) |-> (hs_low_cnt == 8'(`H_SYNC)))
        else $error("hs low pulse width differs from H_SYNC");

    a_sync_blank : assert property (@(posedge sys_clk) disable iff (!rst_n)
        (!vga_hs || !vga_vs) |-> (vga_rgb == 16'd0))
        else $error("pixel not black during sync");

    // gray form, red = blue = green msbs
    a_gray_form : assert property (@(posedge sys_clk) disable iff (!rst_n)
        (vga_rgb[15:11] == vga_rgb[4:0]) && (vga_rgb[10:6] == vga_rgb[15:11]))
        else $error("pixel is not gray565");

endmodule

// ==== test/tb_cam_vga.sv ====
// Camera to VGA testbench
`timescale 1ns/100ps
`include "cam_vga_defs.svh"

module tb_cam_vga;

    localparam int H_ACT     = `H_SYNC + `H_BACK;   // first active column
    localparam int V_ACT     = `V_SYNC + `V_BACK;   // first active line
    localparam int FRAME_PIX = `FRAME_W * `FRAME_H;
    localparam int TIMEOUT   = 8000;                // ~20 display frames

    logic        sys_clk;
    logic        rst_n;
    logic        cam_vsync;
    logic        cam_href;
    logic [7:0]  cam_data;
    logic        vga_hs;
    logic        vga_vs;
    logic [15:0] vga_rgb;
    logic [15:0] frames [3][FRAME_PIX];             // random camera frames
    int          shown;                             // index of frame on screen or -1
    int          cycle_cnt;

    cam_vga_top UUT (.*);

    bind cam_vga_top cam_vga_properties u_props (
        .sys_clk(sys_clk), .rst_n(rst_n), .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_rgb(vga_rgb)
    );

    initial begin
        sys_clk = 1'b0;
        forever #4 sys_clk = ~sys_clk;              // 8 ns period
    end

    // ----------------------------------------
    // timeout watchdog
    // ----------------------------------------
    always @(posedge sys_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("TB FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s expected %0h actual %0h", name, exp, act);
            $display("TB FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    // luma per BT.601 weights, then packed back as gray565
    function automatic logic [15:0] gray565(input logic [15:0] pix);
        logic [7:0]  r8;
        logic [7:0]  g8;
        logic [7:0]  b8;
        logic [15:0] sum;
        logic [7:0]  y;
        r8  = {pix[15:11], pix[15:13]};
        g8  = {pix[10:5], pix[10:9]};
        b8  = {pix[4:0], pix[4:2]};
        sum = 16'd77 * {8'd0, r8} + 16'd150 * {8'd0, g8} + 16'd29 * {8'd0, b8};
        y   = sum[15:8];
        return {y[7:3], y[7:2], y[7:3]};
    endfunction

    task automatic wait_sync_fall(input bit on_vs);
        logic prev;
        prev = on_vs ? vga_vs : vga_hs;
        @(negedge sys_clk);
        while (!(prev && !(on_vs ? vga_vs : vga_hs))) begin
            prev = on_vs ? vga_vs : vga_hs;
            @(negedge sys_clk);
        end
    endtask

    task automatic check_sync_spacing();
        int t0;
        wait_sync_fall(1'b0);
        t0 = cycle_cnt;
        wait_sync_fall(1'b0);
        check_value("hs period", 32'(`H_TOTAL), 32'(cycle_cnt - t0));
        wait_sync_fall(1'b1);
        t0 = cycle_cnt;
        wait_sync_fall(1'b1);
        check_value("vs period", 32'(`H_TOTAL * `V_TOTAL), 32'(cycle_cnt - t0));
    endtask

    // ----------------------------------------
    // one full display frame vs model
    // ----------------------------------------
    task automatic check_display_frame(input string name);
        logic [15:0] exp_rgb;
        int          h;
        int          v;
        wait_sync_fall(1'b1);                       // output position 0,0
        for (int i = 0; i < `H_TOTAL * `V_TOTAL; i++) begin
            h       = i % `H_TOTAL;
            v       = i / `H_TOTAL;
            exp_rgb = 16'd0;                        // blanking or no frame yet
            if (shown >= 0 && h >= H_ACT && h < H_ACT + `FRAME_W &&
                v >= V_ACT && v < V_ACT + `FRAME_H) begin
                exp_rgb = gray565(frames[shown][(v - V_ACT) * `FRAME_W + (h - H_ACT)]);
            end
            check_value(name, 32'(exp_rgb), 32'(vga_rgb));
            @(negedge sys_clk);
        end
    endtask

    task automatic send_frame(input int f, input bit noisy);
        int          gap;
        logic [15:0] p;
        cam_vsync = 1'b1;
        repeat (4) @(negedge sys_clk);
        cam_vsync = 1'b0;                           // frame opens
        for (int y = 0; y < `FRAME_H; y++) begin
            gap = int'($urandom_range(4, 1));
            repeat (gap) begin
                cam_href = 1'b0;
                cam_data = noisy ? 8'($urandom) : 8'h00;    // junk outside href
                @(negedge sys_clk);
            end
            for (int x = 0; x < `FRAME_W; x++) begin
                p        = frames[f][y * `FRAME_W + x];
                cam_href = 1'b1;
                cam_data = p[15:8];                 // hi first
                @(negedge sys_clk);
                cam_data = p[7:0];
                @(negedge sys_clk);
            end
            if (noisy && (y % 2) == 1) begin
                cam_data = 8'($urandom);            // odd trailing byte
                @(negedge sys_clk);
            end
            cam_href = 1'b0;
        end
        cam_data = 8'h00;
        repeat (2) @(negedge sys_clk);
        cam_vsync = 1'b1;
        repeat (8) @(negedge sys_clk);              // drain capture and luma pipe
        shown = f;
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        void'($urandom(70));
        rst_n     = 1'b0;
        cam_vsync = 1'b1;                           // idle between frames
        cam_href  = 1'b0;
        cam_data  = 8'h00;
        shown     = -1;
        cycle_cnt = 0;
        for (int f = 0; f < 3; f++) begin
            for (int i = 0; i < FRAME_PIX; i++) begin
                frames[f][i] = 16'($urandom);
            end
        end
        repeat (5) @(posedge sys_clk);
        @(negedge sys_clk);
        check_value("hs after reset", 32'd1, 32'(vga_hs));
        check_value("vs after reset", 32'd1, 32'(vga_vs));
        rst_n = 1'b1;
        check_display_frame("blank before frame");
        check_sync_spacing();
        send_frame(0, 1'b0);
        check_display_frame("first frame");
        send_frame(1, 1'b1);                        // junk and odd bytes
        check_display_frame("noisy frame");
        send_frame(2, 1'b0);
        check_display_frame("replacement frame");
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
src/cam_vga_pkg.sv
src/cmos_capture.sv
src/rgb2gray.sv
src/frame_buffer.sv
src/vga_driver.sv
src/cam_vga_top.sv
test/cam_vga_properties.sv
test/tb_cam_vga.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of tb_cam_vga

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cam_vga -f tb.f -o sim_cam_vga
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_cam_vga > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
